// File: include/hart_consts.svh
`ifndef HART_CONSTS_SVH
`define HART_CONSTS_SVH

// major opcodes of the instruction classes the hart executes
`define HART_OP_LUI    7'b0110111
`define HART_OP_AUIPC  7'b0010111
`define HART_OP_JAL    7'b1101111
`define HART_OP_JALR   7'b1100111
`define HART_OP_BRANCH 7'b1100011
`define HART_OP_LOAD   7'b0000011
`define HART_OP_STORE  7'b0100011
`define HART_OP_IMM    7'b0010011
`define HART_OP_REG    7'b0110011
`define HART_OP_SYSTEM 7'b1110011

// funct3 of the conditional branches
`define HART_F3_BEQ  3'b000
`define HART_F3_BNE  3'b001
`define HART_F3_BLT  3'b100
`define HART_F3_BGE  3'b101
`define HART_F3_BLTU 3'b110
`define HART_F3_BGEU 3'b111

// funct3 of the alu operations, bit 30 picks sub and sra
`define HART_F3_ADD  3'b000
`define HART_F3_SLL  3'b001
`define HART_F3_SLT  3'b010
`define HART_F3_SLTU 3'b011
`define HART_F3_XOR  3'b100
`define HART_F3_SR   3'b101
`define HART_F3_OR   3'b110
`define HART_F3_AND  3'b111

// writeback sources
`define HART_WB_ALU 2'd0
`define HART_WB_MEM 2'd1
`define HART_WB_PC4 2'd2

`define HART_EBREAK     32'h00100073
`define HART_NOP        32'h00000013 // addi x0, x0, 0
`define HART_RESET_ADDR 32'h00000000

`endif

// File: logic/hart_pkg.sv
package hart_pkg;

  // one 32-bit word, used for data, addresses and instructions alike
  typedef logic [31:0] word_t;

  // index into the integer register file, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // alu operation as {funct7[5], funct3}
  // bit 3 only matters for add/sub and srl/sra
  typedef logic [3:0] alu_op_t;

  // which value goes back to rd: alu result, load data or pc+4
  typedef logic [1:0] wb_sel_t;

endpackage

// File: logic/hart_bus_if.sv
`timescale 1ns/1ps

// decode to execute, one instruction per cycle with its operands already read
interface ex_bus_if;
  logic              valid;
  hart_pkg::word_t   pc;
  hart_pkg::word_t   inst;
  hart_pkg::word_t   op1;      // rs1 or pc
  hart_pkg::word_t   op2;      // rs2 or the immediate
  hart_pkg::word_t   rs2_data; // needed by branches and stores whatever op2 holds
  hart_pkg::word_t   imm;
  hart_pkg::alu_op_t alu_op;
  logic              jal;
  logic              jalr;
  logic              branch;
  logic              mem_read;
  logic              mem_write;
  logic              reg_write;
  hart_pkg::wb_sel_t wb_sel;
  hart_pkg::reg_addr_t rd;

  modport src (output valid, pc, inst, op1, op2, rs2_data, imm, alu_op, jal, jalr, branch,
               mem_read, mem_write, reg_write, wb_sel, rd);
  modport dst (input valid, pc, inst, op1, op2, rs2_data, imm, alu_op, jal, jalr, branch,
               mem_read, mem_write, reg_write, wb_sel, rd);
endinterface

// execute to memory/writeback
interface mem_bus_if;
  logic              valid;
  hart_pkg::word_t   pc;
  hart_pkg::word_t   next_pc; // already resolved, retired as is
  hart_pkg::word_t   inst;
  hart_pkg::word_t   result;  // alu result, doubles as the data address
  hart_pkg::word_t   store_data;
  logic              mem_read;
  logic              mem_write;
  logic              reg_write;
  hart_pkg::wb_sel_t wb_sel;
  hart_pkg::reg_addr_t rd;
  logic              halt;

  modport src (output valid, pc, next_pc, inst, result, store_data, mem_read, mem_write,
               reg_write, wb_sel, rd, halt);
  modport dst (input valid, pc, next_pc, inst, result, store_data, mem_read, mem_write,
               reg_write, wb_sel, rd, halt);
endinterface

// File: logic/hart_fetch.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_fetch #(
  parameter hart_pkg::word_t RESET_ADDR = `HART_RESET_ADDR
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_redirect,    // taken branch or jump from execute
  input  hart_pkg::word_t i_redirect_pc,
  output hart_pkg::word_t o_imem_raddr,
  input  hart_pkg::word_t i_imem_rdata,  // answers in the same cycle
  output logic            o_valid,       // IF/ID register
  output hart_pkg::word_t o_pc,
  output hart_pkg::word_t o_inst
);

  hart_pkg::word_t pc;

  // the redirect target wins over the sequential pc
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= RESET_ADDR;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign o_imem_raddr = pc;

  // the word fetched this cycle is on the wrong path when execute redirects
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= !i_redirect;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc   <= pc;
    o_inst <= i_redirect ? `HART_NOP : i_imem_rdata; // squashed slot becomes a nop
  end

endmodule

// File: logic/hart_regfile.sv
`timescale 1ns/1ps

module hart_regfile (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_rd_wen,
  input  hart_pkg::reg_addr_t i_rs1_raddr,
  input  hart_pkg::reg_addr_t i_rs2_raddr,
  input  hart_pkg::reg_addr_t i_rd_waddr,
  input  hart_pkg::word_t     i_rd_wdata,
  output hart_pkg::word_t     o_rs1_rdata,
  output hart_pkg::word_t     o_rs2_rdata
);

  hart_pkg::word_t regs [1:31]; // x0 has no storage

  logic wr_live;
  assign wr_live = i_rd_wen && (i_rd_waddr != '0); // writes to x0 are dropped

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // a write landing this cycle is seen by decode right away, which closes
  // the gap to the instruction three slots behind the writer
  function automatic hart_pkg::word_t read_port(hart_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_live && (addr == i_rd_waddr)) begin
      return i_rd_wdata;
    end
    return regs[addr];
  endfunction

  assign o_rs1_rdata = read_port(i_rs1_raddr);
  assign o_rs2_rdata = read_port(i_rs2_raddr);

endmodule

// File: logic/hart_decode.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_decode (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_flush,    // redirect from execute kills the decoding slot
  input  logic                i_valid,
  input  hart_pkg::word_t     i_pc,
  input  hart_pkg::word_t     i_inst,
  input  logic                i_rd_wen,   // register write from writeback
  input  hart_pkg::reg_addr_t i_rd_waddr,
  input  hart_pkg::word_t     i_rd_wdata,
  ex_bus_if.src               ex
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  hart_pkg::reg_addr_t rs1_raddr;
  hart_pkg::word_t     rs1_rdata;
  hart_pkg::word_t     rs2_rdata;
  hart_pkg::word_t     i_imm, s_imm, b_imm, u_imm, j_imm;
  hart_pkg::word_t     imm;
  hart_pkg::alu_op_t   alu_op;
  hart_pkg::wb_sel_t   wb_sel;
  logic                jal, jalr, branch, mem_read, mem_write, reg_write;
  logic                use_pc, use_imm; // operand selects

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];

  // lui holds immediate bits in the rs1 field, so it reads x0 and adds
  assign rs1_raddr = (opcode == `HART_OP_LUI) ? '0 : i_inst[19:15];

  hart_regfile u_regfile (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rd_wen    (i_rd_wen),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (i_inst[24:20]),
    .i_rd_waddr  (i_rd_waddr),
    .i_rd_wdata  (i_rd_wdata),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  // immediate formats, all sign extended from bit 31
  assign i_imm = {{20{i_inst[31]}}, i_inst[31:20]};
  assign s_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign b_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign u_imm = {i_inst[31:12], 12'd0};
  assign j_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    jal       = 1'b0;
    jalr      = 1'b0;
    branch    = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    use_pc    = 1'b0;
    use_imm   = 1'b1;
    imm       = i_imm;
    alu_op    = {1'b0, `HART_F3_ADD}; // address and target sums use add
    wb_sel    = `HART_WB_ALU;
    case (opcode)
      `HART_OP_LUI: begin
        reg_write = 1'b1;
        imm       = u_imm;
      end
      `HART_OP_AUIPC: begin
        reg_write = 1'b1;
        use_pc    = 1'b1;
        imm       = u_imm;
      end
      `HART_OP_JAL: begin
        jal       = 1'b1;
        reg_write = 1'b1;
        imm       = j_imm;
        wb_sel    = `HART_WB_PC4;
      end
      `HART_OP_JALR: begin
        jalr      = 1'b1;
        reg_write = 1'b1;
        wb_sel    = `HART_WB_PC4;
      end
      `HART_OP_BRANCH: begin
        branch  = 1'b1;
        use_imm = 1'b0;
        imm     = b_imm;
      end
      `HART_OP_LOAD: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
        wb_sel    = `HART_WB_MEM;
      end
      `HART_OP_STORE: begin
        mem_write = 1'b1;
        imm       = s_imm;
      end
      `HART_OP_IMM: begin
        reg_write = 1'b1;
        alu_op    = {(funct3 == `HART_F3_SR) && i_inst[30], funct3}; // only srai uses bit 30
      end
      `HART_OP_REG: begin
        reg_write = 1'b1;
        use_imm   = 1'b0;
        alu_op    = {i_inst[30], funct3};
      end
      default: begin
        reg_write = 1'b0; // ebreak and anything unknown write nothing
      end
    endcase
  end

  // ID/EX register, only valid is cleared
  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    ex.pc        <= i_pc;
    ex.inst      <= i_inst;
    ex.op1       <= use_pc ? i_pc : rs1_rdata;
    ex.op2       <= use_imm ? imm : rs2_rdata;
    ex.rs2_data  <= rs2_rdata;
    ex.imm       <= imm;
    ex.alu_op    <= alu_op;
    ex.jal       <= jal;
    ex.jalr      <= jalr;
    ex.branch    <= branch;
    ex.mem_read  <= mem_read;
    ex.mem_write <= mem_write;
    ex.reg_write <= reg_write;
    ex.wb_sel    <= wb_sel;
    ex.rd        <= reg_write ? i_inst[11:7] : 5'd0; // stores and branches report no rd
  end

endmodule

// File: logic/hart_execute.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_execute (
  input  logic            i_clk,
  input  logic            i_rst,
  ex_bus_if.dst           ex,
  mem_bus_if.src          mem,
  output logic            o_redirect,    // also flushes fetch and decode
  output hart_pkg::word_t o_redirect_pc
);

  hart_pkg::word_t alu_res;
  hart_pkg::word_t br_target;
  hart_pkg::word_t jalr_target;
  hart_pkg::word_t next_pc;
  logic [4:0]      shamt;
  logic            cond;  // branch condition holds
  logic            taken;

  assign shamt = ex.op2[4:0];

  always_comb begin
    case (ex.alu_op[2:0])
      `HART_F3_ADD:  alu_res = ex.alu_op[3] ? ex.op1 - ex.op2 : ex.op1 + ex.op2;
      `HART_F3_SLL:  alu_res = ex.op1 << shamt;
      `HART_F3_SLT:  alu_res = {31'd0, $signed(ex.op1) < $signed(ex.op2)};
      `HART_F3_SLTU: alu_res = {31'd0, ex.op1 < ex.op2};
      `HART_F3_XOR:  alu_res = ex.op1 ^ ex.op2;
      `HART_F3_SR:   alu_res = ex.alu_op[3] ? $unsigned($signed(ex.op1) >>> shamt)
                                            : ex.op1 >> shamt;
      `HART_F3_OR:   alu_res = ex.op1 | ex.op2;
      `HART_F3_AND:  alu_res = ex.op1 & ex.op2;
    endcase
  end

  // op1 holds rs1 for branches, op2 is not needed since rs2 travels on its own
  always_comb begin
    case (ex.inst[14:12])
      `HART_F3_BEQ:  cond = ex.op1 == ex.rs2_data;
      `HART_F3_BNE:  cond = ex.op1 != ex.rs2_data;
      `HART_F3_BLT:  cond = $signed(ex.op1) < $signed(ex.rs2_data);
      `HART_F3_BGE:  cond = $signed(ex.op1) >= $signed(ex.rs2_data);
      `HART_F3_BLTU: cond = ex.op1 < ex.rs2_data;
      `HART_F3_BGEU: cond = ex.op1 >= ex.rs2_data;
      default:       cond = 1'b0;
    endcase
  end

  assign br_target   = ex.pc + ex.imm;             // branches and jal
  assign jalr_target = {alu_res[31:1], 1'b0};      // alu already summed rs1 and imm
  assign taken       = ex.jal || ex.jalr || (ex.branch && cond);

  assign o_redirect    = ex.valid && taken;
  assign o_redirect_pc = ex.jalr ? jalr_target : br_target;
  assign next_pc       = taken ? o_redirect_pc : ex.pc + 32'd4;

  // EX/MEM register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mem.valid <= 1'b0;
    end else begin
      mem.valid <= ex.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    mem.pc         <= ex.pc;
    mem.next_pc    <= next_pc;
    mem.inst       <= ex.inst;
    mem.result     <= alu_res;
    mem.store_data <= ex.rs2_data;
    mem.mem_read   <= ex.mem_read;
    mem.mem_write  <= ex.mem_write;
    mem.reg_write  <= ex.reg_write;
    mem.wb_sel     <= ex.wb_sel;
    mem.rd         <= ex.rd;
    mem.halt       <= ex.inst == `HART_EBREAK;
  end

endmodule

// File: logic/hart_mem_wb.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_mem_wb (
  input  logic                i_clk,
  input  logic                i_rst,
  mem_bus_if.dst              mem,
  output hart_pkg::word_t     o_dmem_addr,
  output hart_pkg::word_t     o_dmem_wdata,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  input  hart_pkg::word_t     i_dmem_rdata,
  output logic                o_rd_wen,
  output hart_pkg::reg_addr_t o_rd_waddr,
  output hart_pkg::word_t     o_rd_wdata,
  output logic                o_retire_valid,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_next_pc,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr
);

  logic                wb_valid;
  logic                wb_halt;
  logic                wb_reg_write;
  hart_pkg::wb_sel_t   wb_sel;
  hart_pkg::reg_addr_t wb_rd;
  hart_pkg::word_t     wb_pc, wb_next_pc, wb_inst, wb_result, wb_load;

  // word accesses only, the low address bits are dropped
  assign o_dmem_addr  = {mem.result[31:2], 2'b00};
  assign o_dmem_wdata = mem.store_data;
  assign o_dmem_ren   = mem.valid && mem.mem_read;
  assign o_dmem_wen   = mem.valid && mem.mem_write;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    wb_pc        <= mem.pc;
    wb_next_pc   <= mem.next_pc;
    wb_inst      <= mem.inst;
    wb_result    <= mem.result;
    wb_load      <= i_dmem_rdata; // read data arrives in the same cycle as the address
    wb_reg_write <= mem.reg_write;
    wb_sel       <= mem.wb_sel;
    wb_rd        <= mem.rd;
    wb_halt      <= mem.halt;
  end

  always_comb begin
    case (wb_sel)
      `HART_WB_MEM: o_rd_wdata = wb_load;
      `HART_WB_PC4: o_rd_wdata = wb_pc + 32'd4; // link address of jal and jalr
      default:      o_rd_wdata = wb_result;
    endcase
  end

  assign o_rd_wen   = wb_valid && wb_reg_write;
  assign o_rd_waddr = o_rd_wen ? wb_rd : 5'd0;

  // the retire record is the writeback stage itself
  assign o_retire_valid    = wb_valid;
  assign o_retire_halt     = wb_valid && wb_halt;
  assign o_retire_inst     = wb_inst;
  assign o_retire_pc       = wb_pc;
  assign o_retire_next_pc  = wb_next_pc;
  assign o_retire_rd_waddr = o_rd_waddr;
  assign o_retire_rd_wdata = o_rd_wdata;

endmodule

// File: logic/hart.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart #(
  parameter hart_pkg::word_t RESET_ADDR = `HART_RESET_ADDR // first fetch address
) (
  input  logic                i_clk,
  input  logic                i_rst,
  output hart_pkg::word_t     o_imem_raddr,
  input  hart_pkg::word_t     i_imem_rdata,
  output hart_pkg::word_t     o_dmem_addr,
  output hart_pkg::word_t     o_dmem_wdata,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  input  hart_pkg::word_t     i_dmem_rdata,
  output logic                o_retire_valid,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::word_t     o_retire_next_pc,
  output hart_pkg::word_t     o_retire_rd_wdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr
);

  logic                redirect;
  hart_pkg::word_t     redirect_pc;
  logic                id_valid;     // IF/ID outputs
  hart_pkg::word_t     id_pc, id_inst;
  logic                rd_wen;       // writeback into the register file
  hart_pkg::reg_addr_t rd_waddr;
  hart_pkg::word_t     rd_wdata;

  ex_bus_if  u_ex_bus ();
  mem_bus_if u_mem_bus ();

  hart_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_imem_raddr  (o_imem_raddr),
    .i_imem_rdata  (i_imem_rdata),
    .o_valid       (id_valid),
    .o_pc          (id_pc),
    .o_inst        (id_inst)
  );

  hart_decode u_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_flush    (redirect),
    .i_valid    (id_valid),
    .i_pc       (id_pc),
    .i_inst     (id_inst),
    .i_rd_wen   (rd_wen),
    .i_rd_waddr (rd_waddr),
    .i_rd_wdata (rd_wdata),
    .ex         (u_ex_bus.src)
  );

  hart_execute u_execute (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .ex            (u_ex_bus.dst),
    .mem           (u_mem_bus.src),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  hart_mem_wb u_mem_wb (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .mem               (u_mem_bus.dst),
    .o_dmem_addr       (o_dmem_addr),
    .o_dmem_wdata      (o_dmem_wdata),
    .o_dmem_ren        (o_dmem_ren),
    .o_dmem_wen        (o_dmem_wen),
    .i_dmem_rdata      (i_dmem_rdata),
    .o_rd_wen          (rd_wen),
    .o_rd_waddr        (rd_waddr),
    .o_rd_wdata        (rd_wdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_next_pc  (o_retire_next_pc),
    .o_retire_rd_wdata (o_retire_rd_wdata),
    .o_retire_rd_waddr (o_retire_rd_waddr)
  );

endmodule

// File: verif/hart_checker.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module hart_checker (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::word_t     i_imem [0:255], // program image shared with the testbench
  input  logic                i_dmem_ren,
  input  logic                i_dmem_wen,
  input  logic                i_retire_valid,
  input  logic                i_retire_halt,
  input  hart_pkg::word_t     i_retire_inst,
  input  hart_pkg::word_t     i_retire_pc,
  input  hart_pkg::word_t     i_retire_next_pc,
  input  hart_pkg::word_t     i_retire_rd_wdata,
  input  hart_pkg::reg_addr_t i_retire_rd_waddr,
  output int                  o_errors,
  output int                  o_records,
  output int                  o_tests
);

  hart_pkg::word_t m_regs [0:31]; // architectural state of the model
  hart_pkg::word_t m_dmem [0:255];
  hart_pkg::word_t m_pc;
  int              m_stores;      // sw executed by the model in this test
  int              m_loads;       // lw executed by the model in this test
  int              dut_writes;    // dmem write strobes seen from the hart
  int              dut_reads;     // dmem read strobes seen from the hart
  int              test_errs;
  logic            running;       // low between a halt and the next reset

  // isa arithmetic, op selected by funct3 and the alternate bit
  function automatic hart_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                              hart_pkg::word_t a, hart_pkg::word_t b);
    case (f3)
      `HART_F3_ADD:  return alt ? a - b : a + b;
      `HART_F3_SLL:  return a << b[4:0];
      `HART_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `HART_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `HART_F3_XOR:  return a ^ b;
      `HART_F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      `HART_F3_OR:   return a | b;
      default:       return a & b;
    endcase
  endfunction

  // executes the instruction at the model pc and hands back its retire record
  function automatic void model_step(output hart_pkg::word_t e_inst,
                                     output hart_pkg::word_t e_pc,
                                     output hart_pkg::word_t e_npc,
                                     output hart_pkg::word_t e_wdata,
                                     output hart_pkg::reg_addr_t e_rd, output logic e_halt);
    hart_pkg::word_t inst, a, b, res, imm_i, imm_s, imm_b, imm_u, imm_j, addr;
    logic [2:0]      f3;
    logic            wr;
    logic            cond;
    inst  = i_imem[m_pc[9:2]];
    f3    = inst[14:12];
    a     = m_regs[inst[19:15]];
    b     = m_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'd0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    e_inst = inst;
    e_pc   = m_pc;
    e_npc  = m_pc + 32'd4;
    e_halt = (inst == `HART_EBREAK);
    res    = '0;
    wr     = 1'b0;
    case (inst[6:0])
      `HART_OP_LUI: begin
        res = imm_u;
        wr  = 1'b1;
      end
      `HART_OP_AUIPC: begin
        res = m_pc + imm_u;
        wr  = 1'b1;
      end
      `HART_OP_JAL: begin
        res = m_pc + 32'd4;
        wr  = 1'b1;
        e_npc = m_pc + imm_j;
      end
      `HART_OP_JALR: begin
        res = m_pc + 32'd4;
        wr  = 1'b1;
        e_npc = (a + imm_i) & ~32'd1; // low bit of the target is dropped
      end
      `HART_OP_BRANCH: begin
        case (f3)
          `HART_F3_BEQ:  cond = (a == b);
          `HART_F3_BNE:  cond = (a != b);
          `HART_F3_BLT:  cond = ($signed(a) < $signed(b));
          `HART_F3_BGE:  cond = ($signed(a) >= $signed(b));
          `HART_F3_BLTU: cond = (a < b);
          default:       cond = (a >= b);
        endcase
        if (cond) e_npc = m_pc + imm_b;
      end
      `HART_OP_LOAD: begin
        addr = a + imm_i;
        res  = m_dmem[addr[9:2]];
        wr   = 1'b1;
        m_loads++;
      end
      `HART_OP_STORE: begin
        addr = a + imm_s;
        m_dmem[addr[9:2]] = b;
        m_stores++;
      end
      `HART_OP_IMM: begin
        res = alu_ref(f3, (f3 == `HART_F3_SR) && inst[30], a, imm_i);
        wr  = 1'b1;
      end
      `HART_OP_REG: begin
        res = alu_ref(f3, inst[30], a, b);
        wr  = 1'b1;
      end
      default: wr = 1'b0;
    endcase
    e_rd    = wr ? inst[11:7] : 5'd0;
    e_wdata = res;
    if (wr && inst[11:7] != 5'd0) m_regs[inst[11:7]] = res;
    m_pc = e_npc;
  endfunction

  task automatic field_err(string field, hart_pkg::word_t exp, hart_pkg::word_t got);
    $display("ERR %0t: test %0d pc %h %s expected %h got %h", $time, o_tests,
             i_retire_pc, field, exp, got);
    o_errors++;
    test_errs++;
  endtask

  initial begin
    o_errors  = 0;
    o_records = 0;
    o_tests   = 0;
    running   = 1'b0;
  end

  always @(posedge i_clk) begin
    hart_pkg::word_t     e_inst, e_pc, e_npc, e_wdata;
    hart_pkg::reg_addr_t e_rd;
    logic                e_halt;
    if (i_rst) begin
      for (int i = 0; i < 256; i++) begin
        if (i < 32) m_regs[i] = '0;
        m_dmem[i] = '0;
      end
      m_pc       = `HART_RESET_ADDR;
      m_stores   = 0;
      m_loads    = 0;
      dut_writes = 0;
      dut_reads  = 0;
      test_errs  = 0;
      running    = 1'b1;
    end else if (running) begin
      if (i_dmem_wen) dut_writes++;
      if (i_dmem_ren) dut_reads++;
      if (i_retire_valid) begin
        model_step(e_inst, e_pc, e_npc, e_wdata, e_rd, e_halt);
        o_records++;
        if (i_retire_inst !== e_inst) field_err("inst", e_inst, i_retire_inst);
        if (i_retire_pc !== e_pc) field_err("pc", e_pc, i_retire_pc);
        if (i_retire_next_pc !== e_npc) field_err("next_pc", e_npc, i_retire_next_pc);
        if (i_retire_rd_waddr !== e_rd) begin
          field_err("rd_waddr", {27'd0, e_rd}, {27'd0, i_retire_rd_waddr});
        end
        if (e_rd != 5'd0 && i_retire_rd_wdata !== e_wdata) begin
          field_err("rd_wdata", e_wdata, i_retire_rd_wdata);
        end
        if (e_halt && !i_retire_halt) begin
          $display("test %0d: ebreak retired at %0t without the halt flag", o_tests, $time);
          o_errors++;
          test_errs++;
        end else if (!e_halt && i_retire_halt) begin
          $display("test %0d: hart halted at %0t before the program reached ebreak",
                   o_tests, $time);
          o_errors++;
          test_errs++;
        end
        // either side ending the program closes the test
        if (e_halt || i_retire_halt) begin
          if (dut_writes != m_stores) begin
            $display("test %0d: hart wrote dmem %0d times but the program stores %0d times",
                     o_tests, dut_writes, m_stores);
            o_errors++;
            test_errs++;
          end
          if (dut_reads != m_loads) begin
            $display("test %0d: hart read dmem %0d times but the program loads %0d times",
                     o_tests, dut_reads, m_loads);
            o_errors++;
            test_errs++;
          end
          $display("test %0d finished: %0d errors", o_tests, test_errs);
          running = 1'b0;
          o_tests++;
        end
      end
    end
  end

endmodule

// File: verif/tb_hart.sv
`timescale 1ns/1ps
`include "hart_consts.svh"

module tb_hart;

  localparam int NUM_TESTS = 5;

  logic                i_clk;
  logic                i_rst;
  hart_pkg::word_t     imem_raddr, imem_rdata;
  hart_pkg::word_t     dmem_addr, dmem_wdata, dmem_rdata;
  logic                dmem_ren, dmem_wen;
  logic                retire_valid, retire_halt;
  hart_pkg::word_t     retire_inst, retire_pc, retire_next_pc, retire_rd_wdata;
  hart_pkg::reg_addr_t retire_rd_waddr;
  hart_pkg::word_t     imem [0:255];
  hart_pkg::word_t     dmem [0:255];
  logic [15:0]         lfsr;
  int                  prog_len;
  int                  wd_cycles;
  int                  errors, records, tests;

  hart u_hart (
    .i_clk (i_clk), .i_rst (i_rst),
    .o_imem_raddr (imem_raddr), .i_imem_rdata (imem_rdata),
    .o_dmem_addr (dmem_addr), .o_dmem_wdata (dmem_wdata),
    .o_dmem_ren (dmem_ren), .o_dmem_wen (dmem_wen), .i_dmem_rdata (dmem_rdata),
    .o_retire_valid (retire_valid), .o_retire_halt (retire_halt),
    .o_retire_inst (retire_inst), .o_retire_pc (retire_pc),
    .o_retire_next_pc (retire_next_pc), .o_retire_rd_wdata (retire_rd_wdata),
    .o_retire_rd_waddr (retire_rd_waddr)
  );

  hart_checker u_checker (
    .i_clk (i_clk), .i_rst (i_rst), .i_imem (imem),
    .i_dmem_ren (dmem_ren), .i_dmem_wen (dmem_wen),
    .i_retire_valid (retire_valid), .i_retire_halt (retire_halt),
    .i_retire_inst (retire_inst), .i_retire_pc (retire_pc),
    .i_retire_next_pc (retire_next_pc), .i_retire_rd_wdata (retire_rd_wdata),
    .i_retire_rd_waddr (retire_rd_waddr),
    .o_errors (errors), .o_records (records), .o_tests (tests)
  );

  // both memories answer in the same cycle, dmem writes land at the edge
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];
  always @(posedge i_clk) begin
    if (dmem_wen) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11, one step per bit handed out
  function automatic logic [31:0] rnd(int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic hart_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                            logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic hart_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                            logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `HART_OP_BRANCH};
  endfunction

  task automatic emit(hart_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // two nops after every writer keep its readers out of the hazard window
  task automatic emit_spaced(hart_pkg::word_t w);
    emit(w);
    emit(`HART_NOP);
    emit(`HART_NOP);
  endtask

  task automatic seed_regs(int count);
    for (int r = 1; r <= count; r++) begin
      emit_spaced({20'(rnd(20)), r[4:0], `HART_OP_LUI});
      emit_spaced(enc_i(rnd(12), r[4:0], `HART_F3_ADD, r[4:0], `HART_OP_IMM));
    end
  endtask

  task automatic build_program(int t);
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  br_f3 [6];
    br_f3 = '{`HART_F3_BEQ, `HART_F3_BNE, `HART_F3_BLT, `HART_F3_BGE, `HART_F3_BLTU,
              `HART_F3_BGEU};
    prog_len = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    case (t)
      0: begin // random alu work on x1..x8
        seed_regs(8);
        for (int k = 0; k < 20; k++) begin
          f3  = rnd(3);
          rd  = 5'd1 + rnd(3);
          rs1 = 5'd1 + rnd(3);
          rs2 = 5'd1 + rnd(3);
          if (rnd(1)) begin
            emit_spaced({1'b0, rnd(1) && (f3 == `HART_F3_ADD || f3 == `HART_F3_SR), 5'd0,
                         rs2, rs1, f3, rd, `HART_OP_REG});
          end else begin
            imm = (f3 == `HART_F3_SLL || f3 == `HART_F3_SR) ?
                  {1'b0, rnd(1) && (f3 == `HART_F3_SR), 5'd0, 5'(rnd(5))} : rnd(12);
            emit_spaced(enc_i(imm, rs1, f3, rd, `HART_OP_IMM));
          end
        end
      end
      1: begin
        for (int k = 0; k < 12; k++) begin
          emit({20'(rnd(20)), 5'(5'd1 + rnd(4)), k[0] ? `HART_OP_AUIPC : `HART_OP_LUI});
        end
      end
      2: begin // stores then loads from the same word addresses
        seed_regs(4);
        for (int k = 0; k < 4; k++) begin
          imm = {6'd0, 4'(rnd(4)), 2'b00};
          emit_spaced({imm[11:5], 5'd1 + k[4:0], 5'd0, 3'b010, imm[4:0], `HART_OP_STORE});
          emit_spaced(enc_i(imm, 5'd0, 3'b010, 5'd5 + k[4:0], `HART_OP_LOAD));
        end
      end
      3: begin // every branch with swapped and equal operands, wrong path writes x9 and x10
        seed_regs(2);
        for (int k = 0; k < 18; k++) begin
          rs1 = (k % 3 == 1) ? 5'd2 : 5'd1;
          rs2 = (k % 3 == 0) ? 5'd2 : 5'd1;
          emit(enc_b(13'd12, rs2, rs1, br_f3[k / 3]));
          emit(enc_i(12'd1, 5'd0, `HART_F3_ADD, 5'd9, `HART_OP_IMM));
          emit(enc_i(12'd2, 5'd0, `HART_F3_ADD, 5'd10, `HART_OP_IMM));
        end
      end
      default: begin
        for (int k = 0; k < 2; k++) begin
          emit({1'b0, 10'd6, 1'b0, 8'd0, 5'd5, `HART_OP_JAL}); // jal x5, +12
          emit(enc_i(12'd1, 5'd0, `HART_F3_ADD, 5'd9, `HART_OP_IMM));
          emit(enc_i(12'd2, 5'd0, `HART_F3_ADD, 5'd10, `HART_OP_IMM));
          emit_spaced({20'd0, 5'd6, `HART_OP_AUIPC});
          emit(enc_i(12'd29, 5'd6, 3'b000, 5'd7, `HART_OP_JALR)); // odd target, lands at +28
          emit(enc_i(12'd1, 5'd0, `HART_F3_ADD, 5'd9, `HART_OP_IMM));
          emit(enc_i(12'd2, 5'd0, `HART_F3_ADD, 5'd10, `HART_OP_IMM));
          emit(enc_i(12'd3, 5'd0, `HART_F3_ADD, 5'd11, `HART_OP_IMM));
        end
      end
    endcase
    emit(`HART_EBREAK);
  endtask

  initial begin
    i_rst     = 1'b1;
    wd_cycles = 0;
    lfsr      = 16'd33;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    // a dry build of every program sizes the watchdog
    for (int t = 0; t < NUM_TESTS; t++) begin
      build_program(t);
      wd_cycles += prog_len * 3 + 20;
    end
    lfsr = 16'd33;
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge i_clk);
      i_rst <= 1'b1;
      build_program(t);
      repeat (8) @(posedge i_clk);
      i_rst <= 1'b0;
      while (tests < t + 1) @(posedge i_clk); // checker counts a test at its halt
    end
    $display("tests %0d, records %0d, errors %0d", tests, records, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles + 8 * NUM_TESTS) @(posedge i_clk);
    $display("timeout: test %0d never reached its halt", tests);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
logic/hart_pkg.sv
logic/hart_bus_if.sv
logic/hart_fetch.sv
logic/hart_regfile.sv
logic/hart_decode.sv
logic/hart_execute.sv
logic/hart_mem_wb.sv
logic/hart.sv
verif/hart_checker.sv
verif/tb_hart.sv

// File: Bender.yml
package:
  name: hart

sources:
  - include_dirs:
      - include
    files:
      - logic/hart_pkg.sv
      - logic/hart_bus_if.sv
      - logic/hart_fetch.sv
      - logic/hart_regfile.sv
      - logic/hart_decode.sv
      - logic/hart_execute.sv
      - logic/hart_mem_wb.sv
      - logic/hart.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/hart_checker.sv
      - verif/tb_hart.sv
